/* design/bnn_pkg.sv */
`default_nettype none

package bnn_pkg;

  localparam int XLEN      = 64;
  localparam int BUF_DEPTH = 8;
  localparam int IDX_W     = 3;
  localparam int CNT_W     = 4;
  localparam int SUM_W     = 10;
  localparam int TAG_W     = 8;
  // ones in one 64-bit word go from 0 to 64
  localparam int POP_W     = 7;

  localparam logic [CNT_W-1:0] MAX_COUNT  = CNT_W'(BUF_DEPTH);
  localparam logic [XLEN-1:0]  WORD_BYTES = XLEN'(XLEN / 8);

  // memory command and size codes
  localparam logic [4:0] MEM_CMD_LOAD = 5'b00000;
  localparam logic [2:0] MEM_TYP_D    = 3'b011;

  typedef enum logic [6:0] {
    FUNCT_LOAD_W  = 7'd0,
    FUNCT_COMPUTE = 7'd1
  } bnn_funct_e;

  typedef enum logic [1:0] {
    MODE_NONE,
    MODE_LOAD,
    MODE_COMPUTE
  } job_mode_e;

  typedef struct packed {
    logic [6:0]      inst_funct;
    logic [4:0]      inst_rs2;
    logic [4:0]      inst_rs1;
    logic            inst_xd;
    logic            inst_xs1;
    logic            inst_xs2;
    logic [4:0]      inst_rd;
    logic [6:0]      inst_opcode;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
  } rocc_cmd_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } rocc_resp_t;

  typedef struct packed {
    logic [XLEN-1:0]  addr;
    logic [TAG_W-1:0] tag;
    logic [4:0]       cmd;
    logic [2:0]       typ;
    logic [XLEN-1:0]  data;
  } mem_req_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  data;
    logic             has_data;
  } mem_resp_t;

  typedef struct packed {
    logic busy;
  } ctrl_out_t;

  // one job as latched at command accept
  typedef struct packed {
    job_mode_e        mode;
    logic [4:0]       rd;
    logic             xd;
    logic [CNT_W-1:0] count;
    logic [XLEN-1:0]  base;
  } job_t;

endpackage

`default_nettype wire

/* design/bnn_ctrl_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module bnn_ctrl_fsm (
  input  wire                             clk_i,
  input  wire                             rst_n_i,
  input  wire                             en_i,
  input  wire                             cmd_v_i,
  input  wire bnn_pkg::rocc_cmd_t         cmd_i,
  output logic                            cmd_ready_o,
  output bnn_pkg::job_t                   job_o,
  output logic                            job_start_o,
  input  wire                             job_done_i,
  input  wire [bnn_pkg::SUM_W-1:0]        sum_i,
  input  wire                             fire_i,
  output logic                            resp_v_o,
  output bnn_pkg::rocc_resp_t             resp_o,
  input  wire                             resp_ready_i,
  output logic                            busy_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_RESP
  } state_e;

  state_e        state_q;
  state_e        state_d;
  bnn_pkg::job_t job_q;
  bnn_pkg::job_t job_dec;
  logic          cmd_fire;

  // decode the command on the bus
  always_comb begin
    job_dec.rd   = cmd_i.inst_rd;
    job_dec.xd   = cmd_i.inst_xd;
    job_dec.base = cmd_i.rs1;
    if (cmd_i.rs2 > bnn_pkg::BUF_DEPTH) begin
      job_dec.count = bnn_pkg::MAX_COUNT;
    end else begin
      job_dec.count = cmd_i.rs2[bnn_pkg::CNT_W-1:0];
    end
    case (cmd_i.inst_funct)
      bnn_pkg::FUNCT_LOAD_W:  job_dec.mode = bnn_pkg::MODE_LOAD;
      bnn_pkg::FUNCT_COMPUTE: job_dec.mode = bnn_pkg::MODE_COMPUTE;
      default: begin
        // no-op finishes at once
        job_dec.mode  = bnn_pkg::MODE_NONE;
        job_dec.count = '0;
      end
    endcase
  end

  assign cmd_ready_o = (state_q == ST_IDLE) && en_i;
  assign cmd_fire    = cmd_v_i && cmd_ready_o;
  assign job_start_o = cmd_fire;

  // counter and addr gen load from the decoded job at accept
  assign job_o = (state_q == ST_IDLE) ? job_dec : job_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cmd_fire) begin
          if (job_done_i) begin
            state_d = job_dec.xd ? ST_RESP : ST_IDLE;
          end else begin
            state_d = ST_RUN;
          end
        end
      end
      ST_RUN: begin
        if (job_done_i) begin
          state_d = job_q.xd ? ST_RESP : ST_IDLE;
        end
      end
      ST_RESP: begin
        if (resp_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      job_q   <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_fire) begin
        job_q <= job_dec;
      end
    end
  end

  // sum in the low bits and fire in the top bit
  always_comb begin
    resp_o.rd   = job_q.rd;
    resp_o.data = '0;
    if (job_q.mode != bnn_pkg::MODE_NONE) begin
      resp_o.data[bnn_pkg::SUM_W-1:0] = sum_i;
      resp_o.data[bnn_pkg::XLEN-1]    = fire_i;
    end
  end

  assign resp_v_o = (state_q == ST_RESP);
  assign busy_o   = (state_q != ST_IDLE);

  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_o));

endmodule

`default_nettype wire

/* design/bnn_word_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module bnn_word_counter (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  input  wire                        job_start_i,
  input  wire [bnn_pkg::CNT_W-1:0]   count_i,
  input  wire                        req_fire_i,
  input  wire                        resp_fire_i,
  output logic [bnn_pkg::IDX_W-1:0]  issue_idx_o,
  output logic                       issue_more_o,
  output logic                       job_done_o
);

  logic [bnn_pkg::CNT_W-1:0] count_q;
  logic [bnn_pkg::CNT_W-1:0] issued_q;
  logic [bnn_pkg::CNT_W-1:0] returned_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q    <= '0;
      issued_q   <= '0;
      returned_q <= '0;
    end else if (job_start_i) begin
      count_q    <= count_i;
      issued_q   <= '0;
      returned_q <= '0;
    end else begin
      if (req_fire_i) begin
        issued_q <= issued_q + 1'b1;
      end
      if (resp_fire_i) begin
        returned_q <= returned_q + 1'b1;
      end
    end
  end

  assign issue_idx_o  = issued_q[bnn_pkg::IDX_W-1:0];
  assign issue_more_o = (issued_q < count_q);

  // empty job finishes at accept and any other on its last reply
  assign job_done_o = (job_start_i && (count_i == '0)) ||
                      (resp_fire_i && (returned_q + 1'b1 == count_q));

  a_ret_le_iss: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    returned_q <= issued_q);

endmodule

`default_nettype wire

/* design/bnn_addr_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module bnn_addr_gen (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  input  wire                        job_start_i,
  input  wire [bnn_pkg::XLEN-1:0]    base_i,
  input  wire [bnn_pkg::IDX_W-1:0]   issue_idx_i,
  input  wire                        issue_more_i,
  input  wire                        mem_req_ready_i,
  output logic                       mem_req_v_o,
  output bnn_pkg::mem_req_t          mem_req_o,
  output logic                       req_fire_o
);

  logic [bnn_pkg::XLEN-1:0] addr_q;

  assign mem_req_v_o = issue_more_i;
  assign req_fire_o  = mem_req_v_o && mem_req_ready_i;

  // step one doubleword per accepted request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      addr_q <= '0;
    end else if (job_start_i) begin
      addr_q <= base_i;
    end else if (req_fire_o) begin
      addr_q <= addr_q + bnn_pkg::WORD_BYTES;
    end
  end

  always_comb begin
    mem_req_o.addr = addr_q;
    mem_req_o.tag  = {{(bnn_pkg::TAG_W - bnn_pkg::IDX_W){1'b0}}, issue_idx_i};
    mem_req_o.cmd  = bnn_pkg::MEM_CMD_LOAD;
    mem_req_o.typ  = bnn_pkg::MEM_TYP_D;
    mem_req_o.data = '0;
  end

endmodule

`default_nettype wire

/* design/bnn_weight_buf.sv */
`timescale 1ns/10ps
`default_nettype none

module bnn_weight_buf (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  input  wire                        wr_en_i,
  input  wire [bnn_pkg::TAG_W-1:0]   idx_i,
  input  wire [bnn_pkg::XLEN-1:0]    data_i,
  output logic [bnn_pkg::XLEN-1:0]   rd_data_o
);

  logic [bnn_pkg::XLEN-1:0] mem_q [bnn_pkg::BUF_DEPTH];
  logic [bnn_pkg::IDX_W-1:0] addr;

  // tag is the word index
  assign addr = idx_i[bnn_pkg::IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[addr] <= data_i;
    end
  end

  assign rd_data_o = mem_q[addr];

  a_wr_idx: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_en_i |-> idx_i < bnn_pkg::BUF_DEPTH);

endmodule

`default_nettype wire

/* design/bnn_xnor_popcount.sv */
`timescale 1ns/10ps
`default_nettype none

module bnn_xnor_popcount (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  input  wire                        clear_i,
  input  wire                        add_i,
  input  wire [bnn_pkg::XLEN-1:0]    act_i,
  input  wire [bnn_pkg::XLEN-1:0]    weight_i,
  input  wire                        thresh_v_i,
  input  wire [bnn_pkg::XLEN-1:0]    thresh_i,
  output logic [bnn_pkg::SUM_W-1:0]  sum_o,
  output logic                       fire_o
);

  logic [bnn_pkg::XLEN-1:0]  match;
  logic [bnn_pkg::POP_W-1:0] pop_cnt;
  logic [bnn_pkg::SUM_W-1:0] acc_q;
  logic [bnn_pkg::SUM_W-1:0] thresh_q;

  function automatic logic [bnn_pkg::POP_W-1:0] popcount(
    input logic [bnn_pkg::XLEN-1:0] w
  );
    logic [bnn_pkg::POP_W-1:0] n;
    n = '0;
    for (int i = 0; i < bnn_pkg::XLEN; i++) begin
      n = n + w[i];
    end
    return n;
  endfunction

  // equal bits mean +1 times +1 or -1 times -1
  assign match   = ~(act_i ^ weight_i);
  assign pop_cnt = popcount(match);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;
    end else if (add_i) begin
      acc_q <= acc_q + {{(bnn_pkg::SUM_W - bnn_pkg::POP_W){1'b0}}, pop_cnt};
    end
  end

  // threshold from the low bits of the message
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      thresh_q <= '0;
    end else if (thresh_v_i) begin
      thresh_q <= thresh_i[bnn_pkg::SUM_W-1:0];
    end
  end

  assign sum_o  = acc_q;
  assign fire_o = (acc_q >= thresh_q);

endmodule

`default_nettype wire

/* design/bnn_rocc_accel.sv */
`timescale 1ns/10ps
`default_nettype none

module bnn_rocc_accel (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  input  wire                        en_i,
  input  wire                        rocc_cmd_v_i,
  input  wire bnn_pkg::rocc_cmd_t    rocc_cmd_data_i,
  output logic                       rocc_cmd_ready_o,
  output logic                       rocc_resp_v_o,
  output bnn_pkg::rocc_resp_t        rocc_resp_data_o,
  input  wire                        rocc_resp_ready_i,
  output logic                       rocc_mem_req_v_o,
  output bnn_pkg::mem_req_t          rocc_mem_req_data_o,
  input  wire                        rocc_mem_req_ready_i,
  input  wire                        rocc_mem_resp_v_i,
  input  wire bnn_pkg::mem_resp_t    rocc_mem_resp_data_i,
  output bnn_pkg::ctrl_out_t         rocc_ctrl_o,
  input  wire                        manycore_req_val_i,
  input  wire [bnn_pkg::XLEN-1:0]    manycore_req_msg_i,
  output logic                       manycore_req_rdy_o
);

  bnn_pkg::job_t              job;
  logic                       job_start;
  logic                       job_done;
  logic [bnn_pkg::SUM_W-1:0]  sum;
  logic                       fire;
  logic                       busy;
  logic [bnn_pkg::IDX_W-1:0]  issue_idx;
  logic                       issue_more;
  logic                       req_fire;
  logic                       reply_v;
  logic                       load_wr;
  logic                       compute_add;
  logic [bnn_pkg::XLEN-1:0]   weight_rd;
  logic                       thresh_v;

  // steer replies by job mode
  assign reply_v     = rocc_mem_resp_v_i && rocc_mem_resp_data_i.has_data;
  assign load_wr     = reply_v && (job.mode == bnn_pkg::MODE_LOAD);
  assign compute_add = reply_v && (job.mode == bnn_pkg::MODE_COMPUTE);

  assign manycore_req_rdy_o = !busy;
  assign thresh_v           = manycore_req_val_i && manycore_req_rdy_o;
  assign rocc_ctrl_o.busy   = busy;

  bnn_ctrl_fsm i_bnn_ctrl_fsm (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .en_i         (en_i),
    .cmd_v_i      (rocc_cmd_v_i),
    .cmd_i        (rocc_cmd_data_i),
    .cmd_ready_o  (rocc_cmd_ready_o),
    .job_o        (job),
    .job_start_o  (job_start),
    .job_done_i   (job_done),
    .sum_i        (sum),
    .fire_i       (fire),
    .resp_v_o     (rocc_resp_v_o),
    .resp_o       (rocc_resp_data_o),
    .resp_ready_i (rocc_resp_ready_i),
    .busy_o       (busy)
  );

  bnn_word_counter i_bnn_word_counter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .job_start_i  (job_start),
    .count_i      (job.count),
    .req_fire_i   (req_fire),
    .resp_fire_i  (reply_v),
    .issue_idx_o  (issue_idx),
    .issue_more_o (issue_more),
    .job_done_o   (job_done)
  );

  bnn_addr_gen i_bnn_addr_gen (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .job_start_i     (job_start),
    .base_i          (job.base),
    .issue_idx_i     (issue_idx),
    .issue_more_i    (issue_more),
    .mem_req_ready_i (rocc_mem_req_ready_i),
    .mem_req_v_o     (rocc_mem_req_v_o),
    .mem_req_o       (rocc_mem_req_data_o),
    .req_fire_o      (req_fire)
  );

  bnn_weight_buf i_bnn_weight_buf (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wr_en_i   (load_wr),
    .idx_i     (rocc_mem_resp_data_i.tag),
    .data_i    (rocc_mem_resp_data_i.data),
    .rd_data_o (weight_rd)
  );

  bnn_xnor_popcount i_bnn_xnor_popcount (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .clear_i    (job_start),
    .add_i      (compute_add),
    .act_i      (rocc_mem_resp_data_i.data),
    .weight_i   (weight_rd),
    .thresh_v_i (thresh_v),
    .thresh_i   (manycore_req_msg_i),
    .sum_o      (sum),
    .fire_o     (fire)
  );

endmodule

`default_nettype wire

/* verif/bnn_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module bnn_tb;

  localparam int CLK_HALF       = 4;
  localparam int CYCLES_PER_ROW = 64;

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_RUN,
    PH_RESP
  } phase_e;

  typedef struct packed {
    logic [6:0]  funct;
    logic [63:0] base;
    logic [63:0] rs2;
    logic        xd;
    logic [4:0]  rd;
    int          thresh;
    logic        thresh_rel;
    logic        req_stall;
    logic        resp_stall;
    logic        en;
  } row_t;

  typedef struct packed {
    logic [63:0] addr;
    logic [7:0]  tag;
  } pend_t;

  logic                clk;
  logic                rst_n;
  logic                en;
  logic                cmd_v;
  bnn_pkg::rocc_cmd_t  cmd_data;
  logic                cmd_ready;
  logic                resp_v;
  bnn_pkg::rocc_resp_t resp_data;
  logic                resp_ready;
  logic                mem_req_v;
  bnn_pkg::mem_req_t   mem_req_data;
  logic                mem_req_ready;
  logic                mem_resp_v;
  bnn_pkg::mem_resp_t  mem_resp_data;
  bnn_pkg::ctrl_out_t  ctrl;
  logic                mc_val;
  logic [63:0]         mc_msg;
  logic                mc_rdy;

  row_t                rows[$];
  pend_t               pending[$];
  logic [63:0]         w_model [8];
  logic [31:0]         rng_state;
  phase_e              phase;
  int                  issued;
  int                  returned;
  int                  cur_count;
  int                  cycle_cnt;
  int                  cycle_limit;
  logic [63:0]         cur_base;
  logic                cur_xd;
  logic                cur_req_stall;
  logic                cur_resp_stall;
  bnn_pkg::rocc_resp_t exp_resp;
  // handshakes seen mid-cycle and completed at the next edge
  logic                s_cmd_fire;
  logic                s_req_fire;
  logic                s_reply;
  logic                s_resp_fire;
  logic                s_mc_fire;

  bnn_rocc_accel i_bnn_rocc_accel (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .en_i                 (en),
    .rocc_cmd_v_i         (cmd_v),
    .rocc_cmd_data_i      (cmd_data),
    .rocc_cmd_ready_o     (cmd_ready),
    .rocc_resp_v_o        (resp_v),
    .rocc_resp_data_o     (resp_data),
    .rocc_resp_ready_i    (resp_ready),
    .rocc_mem_req_v_o     (mem_req_v),
    .rocc_mem_req_data_o  (mem_req_data),
    .rocc_mem_req_ready_i (mem_req_ready),
    .rocc_mem_resp_v_i    (mem_resp_v),
    .rocc_mem_resp_data_i (mem_resp_data),
    .rocc_ctrl_o          (ctrl),
    .manycore_req_val_i   (mc_val),
    .manycore_req_msg_i   (mc_msg),
    .manycore_req_rdy_o   (mc_rdy)
  );

  always #CLK_HALF clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic rand_bit();
    rng_state = lfsr_step(rng_state);
    return rng_state[0];
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(rand_bit());
    end
    return v;
  endfunction

  // memory contents seeded from every address bit
  function automatic logic [63:0] mem_word(input logic [63:0] addr);
    logic [31:0] s;
    logic [63:0] w;
    s = addr[63:32] ^ {addr[28:0], addr[31:29]} ^ 32'h5a5a_1234;
    if (s == '0) begin
      s = 32'h1;
    end
    w = '0;
    for (int i = 0; i < 64; i++) begin
      s = lfsr_step(s);
      w = {w[62:0], s[0]};
    end
    return w;
  endfunction

  function automatic int job_len(input logic [6:0] funct, input logic [63:0] rs2);
    if (funct != bnn_pkg::FUNCT_LOAD_W && funct != bnn_pkg::FUNCT_COMPUTE) begin
      return 0;
    end
    if (rs2 > 64'd8) begin
      return 8;
    end
    return int'(rs2[3:0]);
  endfunction

  task automatic fail_run();
    $display("Errors found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("Fail %s: got %h, expected %h", name, act, exp);
      fail_run();
    end
  endtask

  task automatic check_resp(input bnn_pkg::rocc_resp_t act, input bnn_pkg::rocc_resp_t exp);
    if (act !== exp) begin
      $display("Fail rocc_resp_data_o: got rd %h data %h, expected rd %h data %h",
               act.rd, act.data, exp.rd, exp.data);
      fail_run();
    end
  endtask

  task automatic check_mem_req(input bnn_pkg::mem_req_t act, input bnn_pkg::mem_req_t exp);
    if (act !== exp) begin
      $display("Fail rocc_mem_req_data_o: got addr %h tag %h cmd %h typ %h data %h",
               act.addr, act.tag, act.cmd, act.typ, act.data);
      $display("  expected addr %h tag %h cmd %h typ %h data %h",
               exp.addr, exp.tag, exp.cmd, exp.typ, exp.data);
      fail_run();
    end
  endtask

  task automatic add_row(input logic [6:0] funct, input logic [63:0] base,
                         input logic [63:0] rs2, input logic xd, input logic [4:0] rd,
                         input int thresh, input logic rel, input logic req_stall,
                         input logic resp_stall, input logic row_en);
    row_t r;
    r = '{funct, base, rs2, xd, rd, thresh, rel, req_stall, resp_stall, row_en};
    rows.push_back(r);
  endtask

  task automatic sample_outputs();
    bnn_pkg::mem_req_t exp_req;
    exp_req.addr = cur_base + 64'(issued) * 64'd8;
    exp_req.tag  = 8'(issued);
    exp_req.cmd  = bnn_pkg::MEM_CMD_LOAD;
    exp_req.typ  = bnn_pkg::MEM_TYP_D;
    exp_req.data = '0;
    check_bit("rocc_ctrl_o.busy", ctrl.busy, phase != PH_IDLE);
    check_bit("rocc_cmd_ready_o", cmd_ready, phase == PH_IDLE && en);
    check_bit("manycore_req_rdy_o", mc_rdy, phase == PH_IDLE);
    check_bit("rocc_resp_v_o", resp_v, phase == PH_RESP);
    check_bit("rocc_mem_req_v_o", mem_req_v, phase == PH_RUN && issued < cur_count);
    if (mem_req_v) begin
      check_mem_req(mem_req_data, exp_req);
    end
    if (resp_v) begin
      check_resp(resp_data, exp_resp);
    end
    s_cmd_fire  = cmd_v && cmd_ready;
    s_req_fire  = mem_req_v && mem_req_ready;
    s_reply     = mem_resp_v;
    s_resp_fire = resp_v && resp_ready;
    s_mc_fire   = mc_val && mc_rdy;
  endtask

  task automatic update_model();
    pend_t p;
    int    pick;
    if (s_req_fire) begin
      p.addr = cur_base + 64'(issued) * 64'd8;
      p.tag  = 8'(issued);
      pending.push_back(p);
      issued++;
    end
    if (s_reply) begin
      returned++;
    end
    if (s_mc_fire) begin
      mc_val = 1'b0;
    end
    case (phase)
      PH_IDLE: begin
        if (s_cmd_fire) begin
          cmd_v    = 1'b0;
          issued   = 0;
          returned = 0;
          if (cur_count == 0) begin
            phase = cur_xd ? PH_RESP : PH_IDLE;
          end else begin
            phase = PH_RUN;
          end
        end
      end
      PH_RUN: begin
        if (s_reply && returned == cur_count) begin
          phase = cur_xd ? PH_RESP : PH_IDLE;
        end
      end
      default: begin
        if (s_resp_fire) begin
          phase = PH_IDLE;
        end
      end
    endcase
    mem_req_ready = cur_req_stall ? rand_bit() : 1'b1;
    resp_ready    = cur_resp_stall ? rand_bit() : 1'b1;
    // reply to any pending request in random order
    mem_resp_v    = 1'b0;
    mem_resp_data = '0;
    if (pending.size() > 0 && (rand_bit() || rand_bit())) begin
      pick = rand_bits(3) % pending.size();
      p    = pending[pick];
      pending.delete(pick);
      mem_resp_v             = 1'b1;
      mem_resp_data.tag      = p.tag;
      mem_resp_data.data     = mem_word(p.addr);
      mem_resp_data.has_data = 1'b1;
    end
  endtask

  task automatic step();
    @(negedge clk);
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      fail_run();
    end
    sample_outputs();
    @(posedge clk);
    #1;
    update_model();
  endtask

  task automatic run_row(input row_t r);
    int sum;
    int thr;
    sum       = 0;
    cur_count = job_len(r.funct, r.rs2);
    if (r.funct == bnn_pkg::FUNCT_COMPUTE) begin
      for (int k = 0; k < cur_count; k++) begin
        sum += $countones(~(mem_word(r.base + 64'(k) * 64'd8) ^ w_model[k]));
      end
    end
    thr = r.thresh_rel ? sum + r.thresh : r.thresh;
    if (thr < 0) begin
      thr = 0;
    end
    // only the low 10 bits of the message count
    mc_msg = {54'h2a_5a5a_c3c3_0f0f, 10'(thr)};
    mc_val = 1'b1;
    while (mc_val) begin
      step();
    end
    exp_resp.rd   = r.rd;
    exp_resp.data = '0;
    if (r.funct == bnn_pkg::FUNCT_LOAD_W || r.funct == bnn_pkg::FUNCT_COMPUTE) begin
      exp_resp.data[9:0] = 10'(sum);
      exp_resp.data[63]  = (sum >= thr);
    end
    cmd_data             = '0;
    cmd_data.inst_funct  = r.funct;
    cmd_data.inst_rs2    = 5'd11;
    cmd_data.inst_rs1    = 5'd10;
    cmd_data.inst_xd     = r.xd;
    cmd_data.inst_xs1    = 1'b1;
    cmd_data.inst_xs2    = 1'b1;
    cmd_data.inst_rd     = r.rd;
    cmd_data.inst_opcode = 7'h0b;
    cmd_data.rs1         = r.base;
    cmd_data.rs2         = r.rs2;
    cur_base       = r.base;
    cur_xd         = r.xd;
    cur_req_stall  = r.req_stall;
    cur_resp_stall = r.resp_stall;
    en             = r.en;
    cmd_v          = 1'b1;
    if (!r.en) begin
      repeat (6) step();
      cmd_v = 1'b0;
      en    = 1'b1;
    end else begin
      while (cmd_v) begin
        step();
      end
      while (phase != PH_IDLE) begin
        step();
      end
      if (r.funct == bnn_pkg::FUNCT_LOAD_W) begin
        for (int k = 0; k < cur_count; k++) begin
          w_model[k] = mem_word(r.base + 64'(k) * 64'd8);
        end
      end
      step();
    end
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    en             = 1'b1;
    cmd_v          = 1'b0;
    cmd_data       = '0;
    resp_ready     = 1'b1;
    mem_req_ready  = 1'b1;
    mem_resp_v     = 1'b0;
    mem_resp_data  = '0;
    mc_val         = 1'b0;
    mc_msg         = '0;
    rng_state      = 32'h11bc_838d;
    phase          = PH_IDLE;
    issued         = 0;
    returned       = 0;
    cur_count      = 0;
    cycle_cnt      = 0;
    cur_base       = '0;
    cur_xd         = 1'b0;
    cur_req_stall  = 1'b0;
    cur_resp_stall = 1'b0;
    exp_resp       = '0;

    // funct, base, rs2, xd, rd, thresh, relative, req stall, resp stall, en
    add_row(bnn_pkg::FUNCT_LOAD_W, 64'h1000, 12, 0, 0, 0, 0, 0, 0, 1);
    add_row(bnn_pkg::FUNCT_COMPUTE, 64'h8000, 8, 1, 5, -1, 1, 0, 0, 1);
    add_row(bnn_pkg::FUNCT_COMPUTE, 64'h8000, 8, 1, 6, 0, 1, 1, 1, 1);
    add_row(bnn_pkg::FUNCT_COMPUTE, 64'h9100, 8, 1, 7, 1, 1, 1, 1, 1);
    add_row(bnn_pkg::FUNCT_LOAD_W, 64'h2_0000_4000, 5, 0, 0, 0, 0, 1, 0, 1);
    add_row(bnn_pkg::FUNCT_COMPUTE, 64'h3000, 5, 1, 9, 100, 0, 1, 1, 1);
    add_row(bnn_pkg::FUNCT_COMPUTE, 64'h3000, 0, 1, 10, 0, 0, 0, 1, 1);
    add_row(bnn_pkg::FUNCT_COMPUTE, 64'h3000, 0, 1, 11, 3, 0, 0, 0, 1);
    add_row(7'h2a, 64'h3000, 4, 1, 12, 0, 0, 0, 1, 1);
    add_row(bnn_pkg::FUNCT_COMPUTE, 64'h1_0000, 20, 0, 13, 0, 0, 1, 0, 1);
    add_row(bnn_pkg::FUNCT_COMPUTE, 64'h5000, 8, 1, 14, 0, 0, 0, 0, 0);
    // wraps past the top of the address space
    add_row(bnn_pkg::FUNCT_COMPUTE, 64'hffff_ffff_ffff_fff0, 4, 1, 31, 0, 1, 1, 1, 1);
    add_row(7'h7f, 64'h0, 0, 0, 15, 0, 0, 0, 0, 1);
    add_row(bnn_pkg::FUNCT_COMPUTE, 64'h7ff8, 8, 1, 1, 0, 1, 1, 1, 1);
    cycle_limit = rows.size() * CYCLES_PER_ROW;

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
design/bnn_pkg.sv
design/bnn_ctrl_fsm.sv
design/bnn_word_counter.sv
design/bnn_addr_gen.sv
design/bnn_weight_buf.sv
design/bnn_xnor_popcount.sv
design/bnn_rocc_accel.sv
verif/bnn_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := bnn_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "FAIL: run did not complete"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
